// File: Makefile
# verilator build and run of the link testbench

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_fw_link -Mdir obj_dir

run: compile
	./obj_dir/Vtb_fw_link | tee run.log
	grep -q "All tests passed!" run.log

clean:
	rm -rf obj_dir run.log

.PHONY: all compile run clean

// File: bench/fw_link_assert.sv
`timescale 1ns/1ps

module fw_link_assert (
    input logic       sysclk,
    input logic       reset,
    input logic [1:0] ctl_out,
    input logic       drive_en,
    input logic       reg_wen
);

    // --------------------
    // bus release only after one driven idle cycle
    assert property (@(posedge sysclk) disable iff (!reset)
        $fell(drive_en) |-> $past(ctl_out) == fw_link_pkg::CTL_IDLE)
        else $error("drive_en dropped without a driven idle cycle");

    // register strobe is a single pulse
    assert property (@(posedge sysclk) disable iff (!reset)
        reg_wen |=> !reg_wen)
        else $error("reg_wen held longer than one cycle");

    // hold never runs past two cycles
    assert property (@(posedge sysclk) disable iff (!reset)
        (ctl_out == fw_link_pkg::CTL_HOLD && $past(ctl_out) == fw_link_pkg::CTL_HOLD)
            |-> $past(ctl_out, 2) != fw_link_pkg::CTL_HOLD)
        else $error("ctl_out stuck in hold");

endmodule

bind fw_link_top fw_link_assert u_assert (
    .sysclk   (sysclk),
    .reset    (reset),
    .ctl_out  (ctl_out),
    .drive_en (drive_en),
    .reg_wen  (reg_wen)
);

// File: bench/tb_fw_link.sv
`timescale 1ns/1ps

module tb_fw_link;

    localparam int N_TESTS     = 21;        // first status plus random tests
    localparam int TEST_NS     = 8000;      // longest test is a foreign write at s100
    localparam int WATCHDOG_NS = N_TESTS * TEST_NS + 10000;

    logic        sysclk;
    logic        reset;
    logic [1:0]  ctl_in;
    logic [7:0]  data_in;
    logic [1:0]  ctl_out;
    logic [7:0]  data_out;
    logic        drive_en;
    logic        lreq;
    logic        reg_wen;
    logic [7:0]  reg_addr;
    logic [31:0] reg_wdata;
    logic [31:0] reg_rdata;

    logic [31:0] regs [0:255];              // register file behind the link
    logic [31:0] model_regs [0:255];        // what it should hold
    logic [7:0]  pkt [0:31];                // packet out and later the expected bytes
    int          pkt_n;
    logic [7:0]  cap [0:31];                // bytes seen on data_out
    int          cap_n;
    logic [7:0]  wq_addr [$];               // logged register writes
    logic [31:0] wq_data [$];
    logic [31:0] seed;
    logic [5:0]  node;                      // model node id
    int          errors;
    int          checks;

    fw_link_top dut (.*);

    initial sysclk = 1'b0;
    always #20 sysclk = ~sysclk;

    assign reg_rdata = regs[reg_addr];      // combinational read

    always @(posedge sysclk) begin
        if (reset && reg_wen) begin
            regs[reg_addr] <= reg_wdata;
            wq_addr.push_back(reg_addr);
            wq_data.push_back(reg_wdata);
        end
    end

    // --------------------
    // helpers
    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [31:0] crc_fold(input logic [31:0] c, input logic [7:0] b);
        logic [31:0] r;
        r = c;
        for (int i = 7; i >= 0; i--)
            r = (r[31] ^ b[i]) ? ((r << 1) ^ 32'h04c1_1db7) : (r << 1);   // msb first
        return r;
    endfunction

    function automatic logic [31:0] crc_over(input int first, input int len);
        logic [31:0] c;
        c = 32'hffff_ffff;
        for (int i = first; i < first + len; i++)
            c = crc_fold(c, pkt[i]);
        return c;
    endfunction

    function automatic logic [7:0] flip_byte(input logic [7:0] b);
        logic [7:0] r;
        for (int i = 0; i < 8; i++)
            r[i] = b[7 - i];
        return r;
    endfunction

    task automatic put_quad(input int idx, input logic [31:0] q);
        for (int i = 0; i < 4; i++)
            pkt[idx + i] = q[31 - 8 * i -: 8];  // big endian
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Fail at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        checks++;
        assert (cond) else begin
            $display("error at %0t ns: %s", $time, what);
            errors++;
        end
    endtask

    task automatic tick();
        @(posedge sysclk);
        #2;                                 // inputs change after the edge
    endtask

    // --------------------
    // phy model
    task automatic send_packet(input logic [2:0] spd);
        int w;
        logic [7:0] d;
        w = (spd == fw_link_pkg::SPD_S100) ? 2 : (spd == fw_link_pkg::SPD_S200) ? 4 : 8;
        tick();
        ctl_in  = fw_link_pkg::CTL_DATA;
        data_in = 8'hff;                    // data-on
        tick();
        data_in = {4'd0, spd, 1'b0};        // speed code ends data-on
        for (int n = 0; n < pkt_n; n++) begin
            for (int k = 0; k < 8 / w; k++) begin
                d = 8'd0;
                for (int i = 0; i < w; i++)
                    d[i] = pkt[n][7 - k * w - i];   // chunk msb on bit 0
                tick();
                data_in = d;
            end
        end
        tick();
        ctl_in  = fw_link_pkg::CTL_IDLE;
        data_in = 8'd0;
    endtask

    task automatic send_status(input logic [15:0] v);
        for (int k = 0; k < 8; k++) begin
            tick();
            ctl_in  = fw_link_pkg::CTL_HOLD;
            data_in = {6'd0, v[14 - 2 * k], v[15 - 2 * k]};
        end
        tick();
        ctl_in  = fw_link_pkg::CTL_IDLE;
        data_in = 8'd0;
    endtask

    task automatic expect_lreq();
        int t;
        logic [5:0] got;
        t = 0;
        @(negedge sysclk);
        while (!lreq && t < 80) begin
            @(negedge sysclk);
            t++;
        end
        check_true(lreq, "no link request seen");
        for (int i = 5; i >= 0; i--) begin
            @(negedge sysclk);
            got[i] = lreq;                  // type then 100
        end
        check_eq("lreq", {26'd0, got}, 32'h04);
    endtask

    task automatic grant_and_capture();
        int t;
        tick();
        ctl_in = fw_link_pkg::CTL_GRANT;
        tick();
        ctl_in = fw_link_pkg::CTL_IDLE;
        t = 0;
        @(negedge sysclk);
        while (!drive_en && t < 10) begin
            @(negedge sysclk);
            t++;
        end
        check_true(drive_en, "link did not take the bus after a grant");
        check_eq("ctl_out", ctl_out, fw_link_pkg::CTL_HOLD);
        cap_n = 0;
        @(negedge sysclk);
        while (drive_en && ctl_out == fw_link_pkg::CTL_DATA && cap_n < 32) begin
            cap[cap_n] = flip_byte(data_out);
            cap_n++;
            @(negedge sysclk);
        end
        check_eq("ctl_out", ctl_out, fw_link_pkg::CTL_IDLE);
        @(negedge sysclk);
        check_eq("drive_en", drive_en, 1'b0);
    endtask

    // --------------------
    // tests
    task automatic do_status(input logic [15:0] v);
        send_status(v);
        repeat (4) @(negedge sysclk);
        check_eq("reg writes", wq_addr.size(), 1);
        if (wq_addr.size() > 0) begin
            check_eq("reg_addr", wq_addr[0], fw_txn_pkg::REG_PHYDATA);
            check_eq("reg_wdata", wq_data[0], {16'd0, v});
        end
        model_regs[fw_txn_pkg::REG_PHYDATA] = {16'd0, v};
        if (v[11:8] == 4'd0)
            node = v[7:2];                  // phy register 0 carries the id
    endtask

    task automatic run_test(input int num, input int kind);
        logic [2:0]  spd;
        logic [15:0] src;
        logic [15:0] dest;
        logic [5:0]  tag;
        logic [7:0]  addr;
        logic [31:0] wdata;
        logic [31:0] r;
        int          err0;
        err0  = errors;
        r     = next_rand();
        spd   = (r[31:30] == 2'd0) ? fw_link_pkg::SPD_S100 :
                (r[31:30] == 2'd1) ? fw_link_pkg::SPD_S200 : fw_link_pkg::SPD_S400;
        src   = next_rand();
        tag   = r[7:2];
        addr  = r[15:8];
        wdata = next_rand();
        dest  = {10'h3ff, (kind == 3) ? (node ^ (6'(r[21:16] % 63) + 6'd1)) : node};
        wq_addr.delete();
        wq_data.delete();
        if (kind == 4) begin
            do_status({r[3:0], r[4] ? 4'd0 : 4'd1 + 4'(r[7:5]), r[13:8], 2'b00});
        end else begin
            put_quad(0, {dest, tag, 2'b00,
                         (kind == 2) ? fw_txn_pkg::TC_QREAD : fw_txn_pkg::TC_QWRITE, 4'd0});
            put_quad(4, {src, 16'hffff});
            put_quad(8, {24'hf00000, addr});
            if (kind == 2) begin
                put_quad(12, ~crc_over(0, 12));
                pkt_n = 16;
            end else begin
                put_quad(12, wdata);
                put_quad(16, ~crc_over(0, 16));
                put_quad(20, wdata);
                put_quad(24, ~crc_over(20, 4));
                pkt_n = 28;
            end
            if (kind == 1)                  // break one crc byte
                pkt[16 + r[25:24] + (r[26] ? 8 : 0)] ^= (r[23:16] | 8'h01);
            send_packet(spd);
            if (kind == 3) begin
                repeat (60) begin
                    @(negedge sysclk);
                    if (lreq || drive_en)
                        check_true(1'b0, "link reacted to a packet for another node");
                end
                check_eq("reg writes", wq_addr.size(), 0);
            end else begin
                expect_lreq();
                grant_and_capture();
                check_eq("ack bytes", cap_n, 1);
                r = (kind == 0) ? fw_txn_pkg::ACK_DONE :
                    (kind == 1) ? fw_txn_pkg::ACK_DATA : fw_txn_pkg::ACK_PEND;
                check_eq("ack", cap[0], {r[3:0], ~r[3:0]});
                check_eq("reg writes", wq_addr.size(), (kind == 0) ? 1 : 0);
                if (kind == 0 && wq_addr.size() > 0) begin
                    check_eq("reg_addr", wq_addr[0], addr);
                    check_eq("reg_wdata", wq_data[0], wdata);
                    model_regs[addr] = wdata;
                end
                if (kind == 2) begin
                    expect_lreq();
                    grant_and_capture();
                    put_quad(0, {src, tag, 2'b00, fw_txn_pkg::TC_QRESP, 4'd0});
                    put_quad(4, {dest, fw_txn_pkg::RC_DONE, 12'd0});
                    put_quad(8, 32'd0);
                    put_quad(12, model_regs[addr]);
                    put_quad(16, ~crc_over(0, 16));
                    check_eq("response bytes", cap_n, 20);
                    for (int i = 0; i < 20; i++)
                        check_eq($sformatf("data_out byte %0d", i), cap[i], pkt[i]);
                end
            end
        end
        $display("test %0d kind %0d speed %0d: %s", num, kind, spd,
                 (errors == err0) ? "ok" : "FAILED");
    endtask

    // --------------------
    initial begin
        seed    = 32'h8b0c_b808;
        errors  = 0;
        checks  = 0;
        node    = 6'd0;
        reset   = 1'b0;
        ctl_in  = fw_link_pkg::CTL_IDLE;
        data_in = 8'd0;
        for (int a = 0; a < 256; a++) begin
            regs[a]       = {a[7:0], ~a[7:0], a[7:0] ^ 8'h3c, a[7:0] + 8'h5a};
            model_regs[a] = regs[a];
        end
        repeat (2) @(posedge sysclk);
        #2 reset = 1'b1;
        do_status({4'h7, 4'd0, 6'(next_rand() % 62) + 6'd1, 2'b00});
        $display("test 0 status, node id %0d: %s", node, (errors == 0) ? "ok" : "FAILED");
        for (int t = 1; t < N_TESTS; t++)
            run_test(t, next_rand() % 5);
        $display("tests %0d, checks %0d, errors %0d", N_TESTS, checks, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("Test failures found");
        $finish;
    end

endmodule

// File: hdl/crc32_byte.sv
`timescale 1ns/1ps

module crc32_byte (
    input  logic        sysclk,
    input  logic        reset,
    input  logic        init,       // restart, may coincide with enable
    input  logic        enable,     // fold in data_byte
    input  logic [7:0]  data_byte,
    output logic [31:0] crc
);

    logic [31:0] base;
    logic [31:0] nxt;

    // one byte of the serial lfsr, msb first
    always_comb begin
        base = init ? fw_txn_pkg::CRC_INIT : crc;
        nxt  = base;
        for (int i = 7; i >= 0; i--) begin
            nxt = {nxt[30:0], 1'b0} ^
                  ((nxt[31] ^ data_byte[i]) ? fw_txn_pkg::CRC_POLY : 32'd0);
        end
    end

    always_ff @(posedge sysclk) begin
        if (!reset)
            crc <= fw_txn_pkg::CRC_INIT;
        else if (enable)
            crc <= nxt;                         // init folded in already
        else if (init)
            crc <= fw_txn_pkg::CRC_INIT;
    end

endmodule

// File: hdl/fw_link_pkg.sv
package fw_link_pkg;

    // --------------------
    // ctl line codes, shared by both directions
    localparam logic [1:0] CTL_IDLE  = 2'd0;
    localparam logic [1:0] CTL_DATA  = 2'd1;    // link sends data, phy receives
    localparam logic [1:0] CTL_HOLD  = 2'd2;    // link holds bus, phy sends status
    localparam logic [1:0] CTL_GRANT = 2'd3;    // phy hands the bus to the link

    // speed code seen on data_in[3:1] after data-on
    localparam logic [2:0] SPD_S100 = 3'b000;   // 2 bits per cycle
    localparam logic [2:0] SPD_S200 = 3'b001;   // 4 bits per cycle
    localparam logic [2:0] SPD_S400 = 3'b101;   // full byte

    // --------------------
    // link request string
    localparam logic [2:0] LREQ_TX_IMM = 3'd0;  // immediate transmit, for acks
    localparam int         LREQ_LEN    = 17;    // serial bits per request

    localparam int STAT_BITS = 16;              // one complete status transfer

    // one received byte, bit order already restored
    typedef struct packed {
        logic       valid;
        logic       sof;        // first byte of the packet
        logic       eof;        // end marker, data is zero
        logic [7:0] data;       // received byte, msb first
    } rx_beat_t;

    // finished status transfer
    typedef struct packed {
        logic        valid;
        logic [15:0] value;
    } status_t;

endpackage

// File: hdl/fw_link_top.sv
`timescale 1ns/1ps

module fw_link_top (
    input  logic        sysclk,
    input  logic        reset,
    input  logic [1:0]  ctl_in,     // phy to link
    input  logic [7:0]  data_in,
    output logic [1:0]  ctl_out,    // link to phy, valid with drive_en
    output logic [7:0]  data_out,
    output logic        drive_en,
    output logic        lreq,
    output logic        reg_wen,
    output logic [7:0]  reg_addr,
    output logic [31:0] reg_wdata,
    input  logic [31:0] reg_rdata   // combinational read of reg_addr
);

    fw_link_pkg::rx_beat_t beat;
    fw_link_pkg::status_t  status;
    fw_txn_pkg::rx_txn_t   txn;
    fw_txn_pkg::tx_job_t   job;
    logic                  tx_grant;
    logic                  tx_done;
    logic                  lreq_trig;

    // --------------------
    // receive side
    phy_rx_deser u_deser (
        .sysclk (sysclk), .reset (reset), .ctl_in (ctl_in), .data_in (data_in),
        .bus_owned (drive_en), .beat (beat), .status (status), .tx_grant (tx_grant)
    );

    rx_packet_parser u_parser (
        .sysclk (sysclk), .reset (reset), .beat (beat), .txn (txn)
    );

    link_responder u_resp (
        .sysclk (sysclk), .reset (reset), .txn (txn), .status (status),
        .tx_grant (tx_grant), .tx_done (tx_done), .reg_wen (reg_wen),
        .reg_addr (reg_addr), .reg_wdata (reg_wdata), .lreq_trig (lreq_trig), .job (job)
    );

    // --------------------
    // transmit side
    tx_serializer u_ser (
        .sysclk (sysclk), .reset (reset), .tx_grant (tx_grant), .job (job),
        .reg_rdata (reg_rdata), .ctl_out (ctl_out), .data_out (data_out),
        .drive_en (drive_en), .tx_done (tx_done)
    );

    phy_request u_lreq (
        .sysclk (sysclk), .reset (reset), .trigger (lreq_trig), .lreq (lreq)
    );

endmodule

// File: hdl/fw_txn_pkg.sv
package fw_txn_pkg;

    // --------------------
    // transaction and response codes
    localparam logic [3:0] TC_QWRITE = 4'd0;
    localparam logic [3:0] TC_QREAD  = 4'd4;
    localparam logic [3:0] TC_QRESP  = 4'd6;
    localparam logic [3:0] RC_DONE   = 4'd0;    // response complete

    // ack codes
    localparam logic [3:0] ACK_DONE = 4'h1;     // write done
    localparam logic [3:0] ACK_PEND = 4'h2;     // read response follows
    localparam logic [3:0] ACK_DATA = 4'hd;     // crc or format error

    localparam logic [7:0] REG_PHYDATA = 8'd2;  // last phy status value

    // --------------------
    // ieee crc-32, msb first
    localparam logic [31:0] CRC_INIT = 32'hffff_ffff;
    localparam logic [31:0] CRC_POLY = 32'h04c1_1db7;

    // parsed request packet
    typedef struct packed {
        logic        valid;
        logic [3:0]  tcode;
        logic [15:0] dest;      // bus and node id of the target
        logic [15:0] src;       // requester
        logic [5:0]  tag;
        logic [7:0]  addr;      // low byte of the offset = register address
        logic [31:0] wdata;     // quadlet write data
        logic        crc_ok;    // all crcs good and length right
    } rx_txn_t;

    typedef enum logic [1:0] {
        TX_NONE,
        TX_ACK,
        TX_QRESP
    } tx_kind_t;

    // what the serializer sends on the next grant
    typedef struct packed {
        tx_kind_t    kind;
        logic [3:0]  ack;
        logic [15:0] dest;      // requester, goes into quadlet 0
        logic [15:0] src;       // our id as addressed
        logic [5:0]  tag;
    } tx_job_t;

endpackage

// File: hdl/link_responder.sv
`timescale 1ns/1ps

module link_responder (
    input  logic                 sysclk,
    input  logic                 reset,
    input  fw_txn_pkg::rx_txn_t  txn,
    input  fw_link_pkg::status_t status,
    input  logic                 tx_grant,
    input  logic                 tx_done,
    output logic                 reg_wen,
    output logic [7:0]           reg_addr,
    output logic [31:0]          reg_wdata,
    output logic                 lreq_trig,
    output fw_txn_pkg::tx_job_t  job
);

    logic [5:0] node_id;
    logic [7:0] rd_addr;        // address of the pending read
    logic       rd_pend;        // response still owed
    logic       hit;

    // busy covers the pending response too, those packets get no ack
    assign hit = txn.valid && (txn.dest[5:0] == node_id) &&
                 (job.kind == fw_txn_pkg::TX_NONE);

    always_ff @(posedge sysclk) begin
        if (!reset) begin
            node_id   <= 6'd0;
            rd_pend   <= 1'b0;
            reg_wen   <= 1'b0;
            reg_addr  <= 8'd0;
            lreq_trig <= 1'b0;
            job.kind  <= fw_txn_pkg::TX_NONE;
        end else begin
            reg_wen   <= 1'b0;
            lreq_trig <= 1'b0;
            // --------------------
            if (status.valid) begin
                reg_wen   <= 1'b1;
                reg_addr  <= fw_txn_pkg::REG_PHYDATA;
                reg_wdata <= {16'd0, status.value};
                if (status.value[11:8] == 4'd0)         // phy register 0
                    node_id <= status.value[7:2];
            end
            // --------------------
            if (hit) begin
                lreq_trig <= 1'b1;
                job.kind  <= fw_txn_pkg::TX_ACK;
                job.dest  <= txn.src;                   // answer goes back
                job.src   <= txn.dest;
                job.tag   <= txn.tag;
                if (!txn.crc_ok) begin
                    job.ack <= fw_txn_pkg::ACK_DATA;
                end else if (txn.tcode == fw_txn_pkg::TC_QWRITE) begin
                    job.ack   <= fw_txn_pkg::ACK_DONE;
                    reg_wen   <= 1'b1;
                    reg_addr  <= txn.addr;
                    reg_wdata <= txn.wdata;
                end else if (txn.tcode == fw_txn_pkg::TC_QREAD) begin
                    job.ack  <= fw_txn_pkg::ACK_PEND;
                    rd_pend  <= 1'b1;
                    rd_addr  <= txn.addr;
                    reg_addr <= txn.addr;
                end else begin
                    job.ack <= fw_txn_pkg::ACK_DATA;    // tcode not handled
                end
            end
            // a status write may have moved the address meanwhile
            if (tx_grant && job.kind == fw_txn_pkg::TX_QRESP)
                reg_addr <= rd_addr;
            // --------------------
            if (tx_done) begin
                if (rd_pend && job.kind == fw_txn_pkg::TX_ACK) begin
                    job.kind  <= fw_txn_pkg::TX_QRESP;  // ask for the bus again
                    lreq_trig <= 1'b1;
                end else begin
                    job.kind <= fw_txn_pkg::TX_NONE;
                    rd_pend  <= 1'b0;
                end
            end
        end
    end

endmodule

// File: hdl/phy_request.sv
`timescale 1ns/1ps

module phy_request (
    input  logic sysclk,
    input  logic reset,
    input  logic trigger,       // one cycle pulse
    output logic lreq
);

    logic [fw_link_pkg::LREQ_LEN-1:0] req;

    assign lreq = req[fw_link_pkg::LREQ_LEN-1];        // msb leads

    // --------------------
    // 01, type, 100, then zero fill
    always_ff @(posedge sysclk) begin
        if (!reset)
            req <= '0;
        else if (trigger)
            req <= {2'b01, fw_link_pkg::LREQ_TX_IMM, 3'b100} << (fw_link_pkg::LREQ_LEN - 8);
        else
            req <= req << 1;                            // idle line stays low
    end

endmodule

// File: hdl/phy_rx_deser.sv
`timescale 1ns/1ps

module phy_rx_deser (
    input  logic                   sysclk,
    input  logic                   reset,
    input  logic [1:0]             ctl_in,
    input  logic [7:0]             data_in,
    input  logic                   bus_owned,   // link drives, ignore ctl_in
    output fw_link_pkg::rx_beat_t  beat,
    output fw_link_pkg::status_t   status,
    output logic                   tx_grant
);

    typedef enum logic [1:0] {S_IDLE, S_STATUS, S_DATA_ON, S_RECV} state_t;

    state_t      st;
    logic [2:0]  speed;         // latched at end of data-on
    logic [7:0]  sh;            // partial byte
    logic [7:0]  sh_next;
    logic [3:0]  nb;            // bits held in sh
    logic [3:0]  step;
    logic        first;         // next byte is sof
    logic [15:0] st_buf;
    logic [4:0]  st_cnt;        // status bits, saturates past 16
    logic        grant_q;       // grant seen last cycle
    logic [1:0]  bits2;
    logic [3:0]  bits4;
    logic [7:0]  bits8;

    // bus bit 0 is the msb of each chunk
    assign bits2 = {<<{data_in[1:0]}};
    assign bits4 = {<<{data_in[3:0]}};
    assign bits8 = {<<{data_in}};

    always_comb begin
        case (speed)
            fw_link_pkg::SPD_S100: begin sh_next = {sh[5:0], bits2}; step = 4'd2; end
            fw_link_pkg::SPD_S200: begin sh_next = {sh[3:0], bits4}; step = 4'd4; end
            fw_link_pkg::SPD_S400: begin sh_next = bits8; step = 4'd8; end
            default:               begin sh_next = sh; step = 4'd0; end  // unknown, drop
        endcase
    end

    always_ff @(posedge sysclk) begin
        if (!reset) begin
            st           <= S_IDLE;
            speed        <= fw_link_pkg::SPD_S100;
            nb           <= 4'd0;
            first        <= 1'b0;
            st_cnt       <= 5'd0;
            grant_q      <= 1'b0;
            tx_grant     <= 1'b0;
            beat.valid   <= 1'b0;
            status.valid <= 1'b0;
        end else begin
            beat.valid   <= 1'b0;
            beat.eof     <= 1'b0;
            status.valid <= 1'b0;
            grant_q      <= (ctl_in == fw_link_pkg::CTL_GRANT);
            tx_grant     <= (st == S_IDLE) && !bus_owned && !grant_q &&
                            (ctl_in == fw_link_pkg::CTL_GRANT);   // rising edge only
            case (st)
                S_IDLE: begin
                    if (!bus_owned && ctl_in == fw_link_pkg::CTL_DATA) begin
                        st <= S_DATA_ON;
                    end else if (!bus_owned && ctl_in == fw_link_pkg::CTL_HOLD) begin
                        st_buf <= {14'd0, bits2};       // first two status bits
                        st_cnt <= 5'd2;
                        st     <= S_STATUS;
                    end
                end
                // --------------------
                S_STATUS: begin
                    case (ctl_in)
                        fw_link_pkg::CTL_HOLD: begin
                            st_buf <= {st_buf[13:0], bits2};
                            if (st_cnt <= 5'(fw_link_pkg::STAT_BITS))
                                st_cnt <= st_cnt + 5'd2;
                        end
                        fw_link_pkg::CTL_DATA: st <= S_DATA_ON;  // cut short by rx
                        fw_link_pkg::CTL_IDLE: begin
                            status.valid <= (st_cnt == 5'(fw_link_pkg::STAT_BITS));
                            status.value <= st_buf;
                            st           <= S_IDLE;
                        end
                        default: st <= S_IDLE;
                    endcase
                end
                // --------------------
                S_DATA_ON: begin
                    if (ctl_in == fw_link_pkg::CTL_DATA && !data_in[0]) begin
                        speed <= data_in[3:1];
                        nb    <= 4'd0;
                        first <= 1'b1;
                        st    <= S_RECV;
                    end else if (ctl_in != fw_link_pkg::CTL_DATA) begin
                        st <= S_IDLE;                   // null packet
                    end
                end
                // --------------------
                S_RECV: begin
                    if (ctl_in == fw_link_pkg::CTL_DATA) begin
                        sh <= sh_next;
                        if (nb + step == 4'd8) begin    // byte complete
                            beat.valid <= 1'b1;
                            beat.sof   <= first;
                            beat.data  <= sh_next;
                            first      <= 1'b0;
                            nb         <= 4'd0;
                        end else begin
                            nb <= nb + step;
                        end
                    end else begin
                        beat.valid <= 1'b1;             // end marker
                        beat.sof   <= 1'b0;
                        beat.eof   <= 1'b1;
                        beat.data  <= 8'd0;
                        st         <= S_IDLE;
                    end
                end
                default: st <= S_IDLE;
            endcase
        end
    end

endmodule

// File: hdl/rx_packet_parser.sv
`timescale 1ns/1ps

module rx_packet_parser (
    input  logic                  sysclk,
    input  logic                  reset,
    input  fw_link_pkg::rx_beat_t beat,
    output fw_txn_pkg::rx_txn_t   txn
);

    logic [23:0] sr;            // last three bytes
    logic [31:0] word;          // quadlet ending with this byte
    logic [4:0]  cnt;           // bytes so far
    logic [4:0]  idx;           // index of the byte on beat
    logic [31:0] crc;
    logic [31:0] crc_snap;      // inverted crc at a boundary
    logic        ok;
    logic        crc_en;
    logic        crc_init;
    logic [4:0]  hdr_end;       // header crc starts here
    logic [4:0]  pkt_len;
    logic        snap;
    logic        chk;

    assign idx      = beat.sof ? 5'd0 : cnt;
    assign word     = {sr, beat.data};
    assign crc_en   = beat.valid && !beat.eof;
    // tcode is stable from byte 3 on
    assign hdr_end  = (txn.tcode == fw_txn_pkg::TC_QREAD) ? 5'd12 : 5'd16;
    assign pkt_len  = (txn.tcode == fw_txn_pkg::TC_QREAD) ? 5'd16 : 5'd28;
    // data crc restarts after the header crc of a write
    assign crc_init = crc_en && (idx == 5'd0 ||
                      (txn.tcode == fw_txn_pkg::TC_QWRITE && idx == 5'd20));
    assign snap     = (idx == hdr_end) || (txn.tcode == fw_txn_pkg::TC_QWRITE && idx == 5'd24);
    assign chk      = (idx == hdr_end + 5'd3) ||
                      (txn.tcode == fw_txn_pkg::TC_QWRITE && idx == 5'd27);

    crc32_byte u_crc (
        .sysclk    (sysclk),
        .reset     (reset),
        .init      (crc_init),
        .enable    (crc_en),
        .data_byte (beat.data),
        .crc       (crc)
    );

    always_ff @(posedge sysclk) begin
        if (!reset) begin
            cnt       <= 5'd0;
            ok        <= 1'b0;
            txn.valid <= 1'b0;
        end else begin
            txn.valid <= 1'b0;
            if (crc_en) begin
                sr  <= word[23:0];
                cnt <= (idx == 5'd31) ? idx : idx + 5'd1;    // saturate, long packet
                case (idx)
                    5'd3: begin                             // quadlet 0
                        txn.dest  <= word[31:16];
                        txn.tag   <= word[15:10];
                        txn.tcode <= word[7:4];
                    end
                    5'd7:  txn.src   <= word[31:16];
                    5'd11: txn.addr  <= word[7:0];
                    5'd15: txn.wdata <= word;               // ignored for reads
                    default: ;
                endcase
                if (snap)
                    crc_snap <= ~crc;
                if (chk)
                    ok <= ok && (word == crc_snap);
                else if (idx == 5'd0)
                    ok <= 1'b1;
            end
            // --------------------
            if (beat.valid && beat.eof) begin
                cnt        <= 5'd0;
                txn.valid  <= (cnt >= 5'd4);                // need a dest at least
                txn.crc_ok <= ok && (cnt == pkt_len);
            end
        end
    end

endmodule

// File: hdl/tx_serializer.sv
`timescale 1ns/1ps

module tx_serializer (
    input  logic                sysclk,
    input  logic                reset,
    input  logic                tx_grant,
    input  fw_txn_pkg::tx_job_t job,
    input  logic [31:0]         reg_rdata,
    output logic [1:0]          ctl_out,
    output logic [7:0]          data_out,
    output logic                drive_en,
    output logic                tx_done
);

    typedef enum logic [1:0] {S_IDLE, S_SEND, S_END, S_REL} state_t;

    state_t      st;
    logic [4:0]  cnt;           // byte index
    logic [31:0] crc;
    logic [31:0] quad;          // response quadlet holding byte cnt
    logic [7:0]  cur;           // byte going out, msb first
    logic        last;

    always_comb begin
        case (cnt[4:2])
            3'd0:    quad = {job.dest, job.tag, 2'b00, fw_txn_pkg::TC_QRESP, 4'd0};
            3'd1:    quad = {job.src, fw_txn_pkg::RC_DONE, 12'd0};
            3'd3:    quad = reg_rdata;
            3'd4:    quad = ~crc;                       // crc frozen after byte 15
            default: quad = 32'd0;
        endcase
        if (job.kind == fw_txn_pkg::TX_ACK)
            cur = {job.ack, ~job.ack};                  // code and its check nibble
        else
            cur = quad[{~cnt[1:0], 3'b000} +: 8];       // high byte first
    end

    assign last = (job.kind == fw_txn_pkg::TX_ACK) ? (cnt == 5'd0) : (cnt == 5'd19);

    crc32_byte u_crc (
        .sysclk    (sysclk),
        .reset     (reset),
        .init      (st == S_IDLE),
        .enable    (st == S_SEND && cnt < 5'd16),
        .data_byte (cur),
        .crc       (crc)
    );

    always_ff @(posedge sysclk) begin
        if (!reset) begin
            st       <= S_IDLE;
            cnt      <= 5'd0;
            ctl_out  <= fw_link_pkg::CTL_IDLE;
            data_out <= 8'd0;
            drive_en <= 1'b0;
            tx_done  <= 1'b0;
        end else begin
            tx_done <= 1'b0;
            case (st)
                S_IDLE: begin
                    if (tx_grant && job.kind != fw_txn_pkg::TX_NONE) begin
                        drive_en <= 1'b1;
                        ctl_out  <= fw_link_pkg::CTL_HOLD;  // one hold cycle
                        cnt      <= 5'd0;
                        st       <= S_SEND;
                    end
                end
                S_SEND: begin
                    ctl_out  <= fw_link_pkg::CTL_DATA;
                    data_out <= {<<{cur}};              // msb on bus bit 0
                    cnt      <= cnt + 5'd1;
                    if (last)
                        st <= S_END;
                end
                S_END: begin
                    ctl_out  <= fw_link_pkg::CTL_IDLE;  // still driven
                    data_out <= 8'd0;
                    st       <= S_REL;
                end
                S_REL: begin
                    drive_en <= 1'b0;                   // phy owns the bus again
                    tx_done  <= 1'b1;
                    st       <= S_IDLE;
                end
                default: st <= S_IDLE;
            endcase
        end
    end

endmodule

// File: src.f
hdl/fw_link_pkg.sv
hdl/fw_txn_pkg.sv
hdl/crc32_byte.sv
hdl/phy_rx_deser.sv
hdl/rx_packet_parser.sv
hdl/link_responder.sv
hdl/tx_serializer.sv
hdl/phy_request.sv
hdl/fw_link_top.sv
bench/fw_link_assert.sv
bench/tb_fw_link.sv
